/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu_subsystem
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cpu_subsystem_sva.sv */
`timescale 1ns/1ps

module cpu_subsystem_sva (
	input logic clk_6m,
	input logic reset,
	input logic rom_9c_ce,
	input logic rom_9d_ce,
	input logic rom_12c_ce,
	input logic rom_12d_ce,
	input logic bus_we,
	input logic scroll0,
	input logic scroll1,
	input logic object,
	input logic latch0,
	input logic latch1,
	input logic backcolor
);

	int fail_count = 0;

	// Only one program ROM drives a CPU at a time
	rom_ce_exclusive: assert property (@(posedge clk_6m) disable iff (reset)
		$onehot0({rom_9c_ce, rom_9d_ce, rom_12c_ce, rom_12d_ce}))
		else begin
			fail_count++;
			$error("more than one ROM enable high");
		end

	////////////////////////////////////////////////////////////////////////////
	// Strobe widths
	////////////////////////////////////////////////////////////////////////////

	latch0_single: assert property (@(posedge clk_6m) disable iff (reset)
		latch0 |=> !latch0)
		else begin
			fail_count++;
			$error("latch0 high for more than one cycle");
		end

	latch1_single: assert property (@(posedge clk_6m) disable iff (reset)
		latch1 |=> !latch1)
		else begin
			fail_count++;
			$error("latch1 high for more than one cycle");
		end

	backcolor_single: assert property (@(posedge clk_6m) disable iff (reset)
		backcolor |=> !backcolor)
		else begin
			fail_count++;
			$error("backcolor high for more than one cycle");
		end

	// Writes reach the master bus inside exactly one shared window
	bus_we_windowed: assert property (@(posedge clk_6m) disable iff (reset)
		bus_we |-> $onehot({scroll0, scroll1, object}))
		else begin
			fail_count++;
			$error("bus_we high without exactly one shared window select");
		end

endmodule

bind cpu_bus_arbiter cpu_subsystem_sva u_sva (
	.clk_6m(clk_6m),
	.reset(reset),
	.rom_9c_ce(rom_9c_ce),
	.rom_9d_ce(rom_9d_ce),
	.rom_12c_ce(rom_12c_ce),
	.rom_12d_ce(rom_12d_ce),
	.bus_we(bus_we),
	.scroll0(scroll0),
	.scroll1(scroll1),
	.object(object),
	.latch0(latch0),
	.latch1(latch1),
	.backcolor(backcolor)
);

/* bench/tb_cpu_subsystem.sv */
`timescale 1ns/1ps

module tb_cpu_subsystem import sys86_map_pkg::*, sys86_timing_pkg::*; ();

	localparam int reset_cycles = 5;

	typedef struct packed {
		logic                  cpu;
		logic [addr_w-1:0]     addr;
		logic [data_w-1:0]     wdata;
		logic                  we;
		logic                  vb;
		logic [bus_addr_w-1:0] bus_addr;
		logic [5:0]            sel;
		logic                  bus_we;
		logic [2:0]            rom;
		logic [rom_addr_w-1:0] rom_addr;
		logic [1:0]            irq;
		logic                  sub_reset;
	} entry_t;

	logic                  clk_6m;
	logic                  reset;
	logic                  vblank;
	logic [addr_w-1:0]     main_addr;
	logic [data_w-1:0]     main_wdata;
	logic                  main_we;
	logic [data_w-1:0]     main_rdata;
	logic [addr_w-1:0]     sub_addr;
	logic [data_w-1:0]     sub_wdata;
	logic                  sub_we;
	logic [data_w-1:0]     sub_rdata;
	logic                  sub_reset;
	logic                  main_irq;
	logic                  sub_irq;
	logic [bus_addr_w-1:0] bus_addr;
	logic [data_w-1:0]     bus_wdata;
	logic                  bus_we;
	logic                  scroll0;
	logic                  scroll1;
	logic                  object;
	logic                  latch0;
	logic                  latch1;
	logic                  backcolor;
	logic [data_w-1:0]     md;
	logic [data_w-1:0]     bus_rdata;
	logic [rom_addr_w-1:0] rom_9c_addr;
	logic                  rom_9c_ce;
	logic [data_w-1:0]     rom_9c_data;
	logic [rom_addr_w-1:0] rom_9d_addr;
	logic                  rom_9d_ce;
	logic [data_w-1:0]     rom_9d_data;
	logic [rom_addr_w-1:0] rom_12c_addr;
	logic                  rom_12c_ce;
	logic [data_w-1:0]     rom_12c_data;
	logic [rom_addr_w-1:0] rom_12d_addr;
	logic                  rom_12d_ce;
	logic [data_w-1:0]     rom_12d_data;

	entry_t table_q[$];
	logic   table_ready = 1'b0;
	int     n_errors = 0;
	int     n_checks = 0;
	int     entry_errors = 0;

	cpu_subsystem u_dut (.*);

	// ROM contents mix every address bit with the ROM number
	function automatic logic [data_w-1:0] rom_pattern(input logic [2:0] idx,
		input logic [rom_addr_w-1:0] a);
		return a[7:0] ^ {1'b0, a[14:8]} ^ {idx, 5'h15};
	endfunction

	assign rom_9c_data = rom_pattern(3'd1, rom_9c_addr);
	assign rom_9d_data = rom_pattern(3'd2, rom_9d_addr);
	assign rom_12c_data = rom_pattern(3'd3, rom_12c_addr);
	assign rom_12d_data = rom_pattern(3'd4, rom_12d_addr);

	// 100 ns period
	initial begin
		clk_6m = 1'b0;
		forever #50 clk_6m = ~clk_6m;
	end

	initial begin
		int limit;
		wait (table_ready);
		limit = table_q.size() * 3 * phase_count + reset_cycles + 40;
		repeat (limit) @(posedge clk_6m);
		$display("watchdog: tests did not finish within %0d clock cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			entry_errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_entry(input int cpu, input logic [15:0] addr, input logic [7:0] wdata,
		input int we, input int vb, input logic [12:0] bus_a, input logic [5:0] sel,
		input int bwe, input int rom, input logic [14:0] rom_a, input logic [1:0] irq,
		input int sres);
		entry_t e;
		e.cpu = cpu[0];
		e.addr = addr;
		e.wdata = wdata;
		e.we = we[0];
		e.vb = vb[0];
		e.bus_addr = bus_a;
		e.sel = sel;
		e.bus_we = bwe[0];
		e.rom = rom[2:0];
		e.rom_addr = rom_a;
		e.irq = irq;
		e.sub_reset = sres[0];
		table_q.push_back(e);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// cpu addr wdata we vblank | bus_addr sel{s0,s1,obj,l0,l1,bc} bus_we
		// rom(0 none 1 9c 2 9d 3 12c 4 12d) rom_addr {main_irq,sub_irq} sub_reset
		add_entry(0, 16'h0123, 8'h5A, 1, 0, 13'h0123, 6'b100000, 1, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h2345, 8'hA5, 1, 0, 13'h0345, 6'b010000, 1, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h4ABC, 8'h3C, 1, 0, 13'h0ABC, 6'b001000, 1, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h0FED, 8'hC3, 1, 0, 13'h0FED, 6'b100000, 1, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h3456, 8'h11, 1, 0, 13'h1456, 6'b010000, 1, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h5F00, 8'h22, 1, 0, 13'h1F00, 6'b001000, 1, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h1234, 8'h00, 0, 0, 13'h1234, 6'b100000, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h4567, 8'h00, 0, 0, 13'h0567, 6'b001000, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'hC5A7, 8'h00, 0, 0, 13'h05A7, 6'b000000, 0, 1, 15'h45A7, 2'b00, 0);
		add_entry(1, 16'h9ABC, 8'h00, 0, 0, 13'h1ABC, 6'b000000, 0, 3, 15'h1ABC, 2'b00, 0);
		add_entry(1, 16'h6DEF, 8'h00, 0, 0, 13'h0DEF, 6'b000000, 0, 4, 15'h6DEF, 2'b00, 0);
		// Banked ROM 9d
		add_entry(0, 16'h6234, 8'h00, 0, 0, 13'h0234, 6'b000000, 0, 2, 15'h0234, 2'b00, 0);
		add_entry(0, 16'h9800, 8'h02, 1, 0, 13'h1800, 6'b000000, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h7FFE, 8'h00, 0, 0, 13'h1FFE, 6'b000000, 0, 2, 15'h5FFE, 2'b00, 0);
		add_entry(0, 16'h9800, 8'hFD, 1, 0, 13'h1800, 6'b000000, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h6001, 8'h00, 0, 0, 13'h0001, 6'b000000, 0, 2, 15'h2001, 2'b00, 0);
		// Latch and backcolor strobes
		add_entry(0, 16'h8000, 8'h77, 1, 0, 13'h0000, 6'b000100, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h8800, 8'h88, 1, 0, 13'h0800, 6'b000010, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(0, 16'h9000, 8'h99, 1, 0, 13'h1000, 6'b000001, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h8000, 8'h44, 1, 0, 13'h0000, 6'b000100, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h8800, 8'h55, 1, 0, 13'h0800, 6'b000010, 0, 0, 15'h0000, 2'b00, 0);
		// Vblank interrupts and their acks
		add_entry(0, 16'h0010, 8'h00, 0, 1, 13'h0010, 6'b100000, 0, 0, 15'h0000, 2'b11, 0);
		add_entry(1, 16'hA800, 8'h00, 1, 0, 13'h0800, 6'b000000, 0, 0, 15'h0000, 2'b10, 0);
		add_entry(0, 16'hA800, 8'h00, 1, 0, 13'h0800, 6'b000000, 0, 0, 15'h0000, 2'b00, 0);
		add_entry(1, 16'h0020, 8'h00, 0, 1, 13'h0020, 6'b100000, 0, 0, 15'h0000, 2'b11, 0);
		add_entry(0, 16'hA800, 8'h00, 1, 0, 13'h0800, 6'b000000, 0, 0, 15'h0000, 2'b01, 0);
		add_entry(1, 16'hA800, 8'h00, 1, 0, 13'h0800, 6'b000000, 0, 0, 15'h0000, 2'b00, 0);
		// Sub CPU hold
		add_entry(0, 16'hA000, 8'h01, 1, 0, 13'h0000, 6'b000000, 0, 0, 15'h0000, 2'b00, 1);
		add_entry(1, 16'h0030, 8'h00, 0, 0, 13'h0030, 6'b100000, 0, 0, 15'h0000, 2'b00, 1);
		add_entry(0, 16'hA000, 8'hFE, 1, 0, 13'h0000, 6'b000000, 0, 0, 15'h0000, 2'b00, 0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus cycle helpers
	////////////////////////////////////////////////////////////////////////////

	// First falling edge after the other CPU's slot has begun and its e is low
	task automatic wait_drive_point(input logic cpu);
		do @(negedge clk_6m);
		while (u_dut.slot_sub == cpu || (cpu ? u_dut.main_e : u_dut.sub_e));
	endtask

	task automatic wait_cycle_end(input logic cpu);
		do @(negedge clk_6m);
		while (!(cpu ? u_dut.sub_e : u_dut.main_e));
	endtask

	task automatic drive_cpu(input logic cpu, input logic [addr_w-1:0] a,
		input logic [data_w-1:0] d, input logic w);
		if (cpu) begin
			sub_addr = a;
			sub_wdata = d;
			sub_we = w;
		end else begin
			main_addr = a;
			main_wdata = d;
			main_we = w;
		end
	endtask

	task automatic check_bus(input entry_t e, input logic strobe_cycle);
		logic [5:0] exp_sel;
		exp_sel = strobe_cycle ? e.sel : {e.sel[5:3], 3'b000};
		check("bus_addr", 32'(bus_addr), 32'(e.bus_addr));
		check("bus_wdata", 32'(bus_wdata), 32'(e.wdata));
		check("bus_we", 32'(bus_we), 32'(e.bus_we));
		check("{scroll0,scroll1,object,latch0,latch1,backcolor}",
			32'({scroll0, scroll1, object, latch0, latch1, backcolor}), 32'(exp_sel));
	endtask

	initial begin
		entry_t                e;
		logic [3:0]            exp_ce;
		logic [rom_addr_w-1:0] got_rom_addr;
		logic [data_w-1:0]     exp_rdata;
		int                    sva_fails;
		void'($urandom(6));
		reset = 1'b1;
		vblank = 1'b0;
		bus_rdata = '0;
		drive_cpu(1'b0, '0, '0, 1'b0);
		drive_cpu(1'b1, '0, '0, 1'b0);
		build_table();
		table_ready = 1'b1;
		repeat (reset_cycles) @(negedge clk_6m);
		check("sub_reset", 32'(sub_reset), 32'd1);
		check("main_irq", 32'(main_irq), 32'd0);
		check("sub_irq", 32'(sub_irq), 32'd0);
		check("bus_we", 32'(bus_we), 32'd0);
		reset = 1'b0;
		foreach (table_q[i]) begin
			e = table_q[i];
			entry_errors = 0;
			if (!e.we) begin
				e.wdata = 8'($urandom);
			end
			wait_drive_point(e.cpu);
			bus_rdata = 8'($urandom);
			vblank = e.vb;
			drive_cpu(e.cpu, e.addr, e.wdata, e.we);
			wait_cycle_end(e.cpu);
			// ROM side is combinational, checked at the e pulse
			exp_ce = (e.rom == 3'd0) ? 4'b0000 : (4'b1000 >> (e.rom - 3'd1));
			check("{rom_9c_ce,rom_9d_ce,rom_12c_ce,rom_12d_ce}",
				32'({rom_9c_ce, rom_9d_ce, rom_12c_ce, rom_12d_ce}), 32'(exp_ce));
			case (e.rom)
				3'd1: got_rom_addr = rom_9c_addr;
				3'd2: got_rom_addr = rom_9d_addr;
				3'd3: got_rom_addr = rom_12c_addr;
				default: got_rom_addr = rom_12d_addr;
			endcase
			if (e.rom != 3'd0) begin
				check("rom_addr", 32'(got_rom_addr), 32'(e.rom_addr));
			end
			exp_rdata = (e.rom == 3'd0) ? bus_rdata : rom_pattern(e.rom, e.rom_addr);
			if (e.cpu) begin
				check("sub_rdata", 32'(sub_rdata), 32'(exp_rdata));
			end else begin
				check("main_rdata", 32'(main_rdata), 32'(exp_rdata));
			end
			check_bus(e, 1'b0);
			// Second cycle of the owner's bus window carries the strobes
			@(negedge clk_6m);
			check_bus(e, 1'b1);
			if (!e.cpu) begin
				check("md", 32'(md), 32'(e.wdata));
			end
			check("main_irq", 32'(main_irq), 32'(e.irq[1]));
			check("sub_irq", 32'(sub_irq), 32'(e.irq[0]));
			check("sub_reset", 32'(sub_reset), 32'(e.sub_reset));
			drive_cpu(e.cpu, '0, '0, 1'b0);
			vblank = 1'b0;
			$display("test %0d %s %s %h: %0d errors", i, e.cpu ? "sub" : "main",
				e.we ? "write" : "read", e.addr, entry_errors);
		end
		sva_fails = u_dut.u_arbiter.u_sva.fail_count;
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			table_q.size(), n_checks, n_errors, sva_fails);
		if (n_errors == 0 && sva_fails == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* hw/bus_phase_gen.sv */
`timescale 1ns/1ps

module bus_phase_gen import sys86_timing_pkg::*; (
	input  logic               clk_6m,
	input  logic               reset,
	output logic [phase_w-1:0] phase,
	output logic               slot_sub,
	output logic               main_e,
	output logic               sub_e
);

	logic [phase_w-1:0] next_phase;

	// Wrap at the end of the bus period
	always_comb begin
		if (phase == phase_w'(phase_count - 1)) begin
			next_phase = '0;
		end else begin
			next_phase = phase + 1'b1;
		end
	end

	// Decodes of next_phase, so the strobes line up with phase
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			phase <= '0;
			slot_sub <= 1'b0;
			main_e <= 1'b0;
			sub_e <= 1'b0;
		end else begin
			phase <= next_phase;
			slot_sub <= (next_phase > slot_main_last);
			main_e <= (next_phase == slot_main_last);
			sub_e <= (next_phase == slot_sub_last);
		end
	end

endmodule

/* hw/cpu_bus_arbiter.sv */
`timescale 1ns/1ps

module cpu_bus_arbiter import sys86_map_pkg::*; (
	input  logic                  clk_6m,
	input  logic                  reset,
	input  logic                  slot_sub,
	input  logic                  main_e,
	// Main CPU side
	input  logic [addr_w-1:0]     main_addr,
	input  logic [data_w-1:0]     main_wdata,
	input  logic                  main_we,
	input  logic                  main_sel_scroll0,
	input  logic                  main_sel_scroll1,
	input  logic                  main_sel_object,
	input  logic                  main_sel_latch0,
	input  logic                  main_sel_latch1,
	input  logic                  main_sel_backcolor,
	input  logic                  main_rom_sel_c,
	input  logic                  main_rom_sel_d,
	input  logic [bank_w-1:0]     main_bank,
	output logic [data_w-1:0]     main_rdata,
	// Sub CPU side
	input  logic [addr_w-1:0]     sub_addr,
	input  logic [data_w-1:0]     sub_wdata,
	input  logic                  sub_we,
	input  logic                  sub_sel_scroll0,
	input  logic                  sub_sel_scroll1,
	input  logic                  sub_sel_object,
	input  logic                  sub_sel_latch0,
	input  logic                  sub_sel_latch1,
	input  logic                  sub_rom_sel_c,
	input  logic                  sub_rom_sel_d,
	output logic [data_w-1:0]     sub_rdata,
	// Master bus
	output logic [bus_addr_w-1:0] bus_addr,
	output logic [data_w-1:0]     bus_wdata,
	output logic                  bus_we,
	output logic                  scroll0,
	output logic                  scroll1,
	output logic                  object,
	output logic                  latch0,
	output logic                  latch1,
	output logic                  backcolor,
	output logic [data_w-1:0]     md,
	input  logic [data_w-1:0]     bus_rdata,
	// Program ROMs
	output logic [rom_addr_w-1:0] rom_9c_addr,
	output logic                  rom_9c_ce,
	input  logic [data_w-1:0]     rom_9c_data,
	output logic [rom_addr_w-1:0] rom_9d_addr,
	output logic                  rom_9d_ce,
	input  logic [data_w-1:0]     rom_9d_data,
	output logic [rom_addr_w-1:0] rom_12c_addr,
	output logic                  rom_12c_ce,
	input  logic [data_w-1:0]     rom_12c_data,
	output logic [rom_addr_w-1:0] rom_12d_addr,
	output logic                  rom_12d_ce,
	input  logic [data_w-1:0]     rom_12d_data
);

	logic                slot_sub_d;
	logic                owner_last;
	logic [addr_w-1:0]   own_addr;
	logic [data_w-1:0]   own_wdata;
	logic                own_we;
	logic                own_scroll0;
	logic                own_scroll1;
	logic                own_object;
	logic                own_latch0;
	logic                own_latch1;

	////////////////////////////////////////////////////////////////////////////
	// Slot owner select
	////////////////////////////////////////////////////////////////////////////

	assign own_addr = slot_sub ? sub_addr : main_addr;
	assign own_wdata = slot_sub ? sub_wdata : main_wdata;
	assign own_we = slot_sub ? sub_we : main_we;
	assign own_scroll0 = slot_sub ? sub_sel_scroll0 : main_sel_scroll0;
	assign own_scroll1 = slot_sub ? sub_sel_scroll1 : main_sel_scroll1;
	assign own_object = slot_sub ? sub_sel_object : main_sel_object;
	assign own_latch0 = slot_sub ? sub_sel_latch0 : main_sel_latch0;
	assign own_latch1 = slot_sub ? sub_sel_latch1 : main_sel_latch1;

	// Second phase of the sub slot is the one after a sub phase
	assign owner_last = slot_sub ? slot_sub_d : main_e;

	// Master bus, one cycle behind the slot
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			slot_sub_d <= 1'b0;
			bus_addr <= '0;
			bus_wdata <= '0;
			bus_we <= 1'b0;
			scroll0 <= 1'b0;
			scroll1 <= 1'b0;
			object <= 1'b0;
			latch0 <= 1'b0;
			latch1 <= 1'b0;
			backcolor <= 1'b0;
			md <= '0;
		end else begin
			slot_sub_d <= slot_sub;
			bus_addr <= own_addr[bus_addr_w-1:0];
			bus_wdata <= own_wdata;
			bus_we <= own_we && (own_scroll0 || own_scroll1 || own_object);
			scroll0 <= own_scroll0;
			scroll1 <= own_scroll1;
			object <= own_object;
			// Latches fire once per bus cycle
			latch0 <= owner_last && own_latch0;
			latch1 <= owner_last && own_latch1;
			backcolor <= main_e && main_sel_backcolor;
			md <= main_wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program ROMs and read return
	////////////////////////////////////////////////////////////////////////////

	assign rom_9c_addr = main_addr[rom_addr_w-1:0];
	assign rom_9d_addr = {main_bank, main_addr[rom_addr_w-bank_w-1:0]};
	assign rom_12c_addr = sub_addr[rom_addr_w-1:0];
	assign rom_12d_addr = sub_addr[rom_addr_w-1:0];

	assign rom_9c_ce = !slot_sub && main_rom_sel_c;
	assign rom_9d_ce = !slot_sub && main_rom_sel_d;
	assign rom_12c_ce = slot_sub && sub_rom_sel_c;
	assign rom_12d_ce = slot_sub && sub_rom_sel_d;

	// Master bus data when no ROM drives the CPU
	assign main_rdata = rom_9c_ce ? rom_9c_data :
		rom_9d_ce ? rom_9d_data : bus_rdata;
	assign sub_rdata = rom_12c_ce ? rom_12c_data :
		rom_12d_ce ? rom_12d_data : bus_rdata;

endmodule

/* hw/cpu_subsystem.sv */
`timescale 1ns/1ps

module cpu_subsystem import sys86_map_pkg::*; (
	input  logic                  clk_6m,
	input  logic                  reset,
	input  logic                  vblank,
	input  logic [addr_w-1:0]     main_addr,
	input  logic [data_w-1:0]     main_wdata,
	input  logic                  main_we,
	output logic [data_w-1:0]     main_rdata,
	input  logic [addr_w-1:0]     sub_addr,
	input  logic [data_w-1:0]     sub_wdata,
	input  logic                  sub_we,
	output logic [data_w-1:0]     sub_rdata,
	output logic                  sub_reset,
	output logic                  main_irq,
	output logic                  sub_irq,
	output logic [bus_addr_w-1:0] bus_addr,
	output logic [data_w-1:0]     bus_wdata,
	output logic                  bus_we,
	output logic                  scroll0,
	output logic                  scroll1,
	output logic                  object,
	output logic                  latch0,
	output logic                  latch1,
	output logic                  backcolor,
	output logic [data_w-1:0]     md,
	input  logic [data_w-1:0]     bus_rdata,
	output logic [rom_addr_w-1:0] rom_9c_addr,
	output logic                  rom_9c_ce,
	input  logic [data_w-1:0]     rom_9c_data,
	output logic [rom_addr_w-1:0] rom_9d_addr,
	output logic                  rom_9d_ce,
	input  logic [data_w-1:0]     rom_9d_data,
	output logic [rom_addr_w-1:0] rom_12c_addr,
	output logic                  rom_12c_ce,
	input  logic [data_w-1:0]     rom_12c_data,
	output logic [rom_addr_w-1:0] rom_12d_addr,
	output logic                  rom_12d_ce,
	input  logic [data_w-1:0]     rom_12d_data
);

	logic              slot_sub;
	logic              main_e;
	logic              sub_e;
	logic              main_sel_scroll0;
	logic              main_sel_scroll1;
	logic              main_sel_object;
	logic              main_sel_latch0;
	logic              main_sel_latch1;
	logic              main_sel_backcolor;
	logic              main_rom_sel_c;
	logic              main_rom_sel_d;
	logic [bank_w-1:0] main_bank;
	logic              sub_sel_scroll0;
	logic              sub_sel_scroll1;
	logic              sub_sel_object;
	logic              sub_sel_latch0;
	logic              sub_sel_latch1;
	logic              sub_rom_sel_c;
	logic              sub_rom_sel_d;

	// Phase number itself is not needed at this level
	bus_phase_gen u_phase (
		.clk_6m(clk_6m),
		.reset(reset),
		.phase(),
		.slot_sub(slot_sub),
		.main_e(main_e),
		.sub_e(sub_e)
	);

	main_addr_decoder u_main_dec (
		.clk_6m(clk_6m),
		.reset(reset),
		.main_e(main_e),
		.vblank(vblank),
		.addr(main_addr),
		.wdata(main_wdata),
		.we(main_we),
		.sel_scroll0(main_sel_scroll0),
		.sel_scroll1(main_sel_scroll1),
		.sel_object(main_sel_object),
		.sel_latch0(main_sel_latch0),
		.sel_latch1(main_sel_latch1),
		.sel_backcolor(main_sel_backcolor),
		.rom_sel_c(main_rom_sel_c),
		.rom_sel_d(main_rom_sel_d),
		.bank(main_bank),
		.irq(main_irq),
		.hold(sub_reset)
	);

	sub_addr_decoder u_sub_dec (
		.clk_6m(clk_6m),
		.reset(reset),
		.sub_e(sub_e),
		.vblank(vblank),
		.addr(sub_addr),
		.we(sub_we),
		.sel_scroll0(sub_sel_scroll0),
		.sel_scroll1(sub_sel_scroll1),
		.sel_object(sub_sel_object),
		.sel_latch0(sub_sel_latch0),
		.sel_latch1(sub_sel_latch1),
		.rom_sel_c(sub_rom_sel_c),
		.rom_sel_d(sub_rom_sel_d),
		.irq(sub_irq)
	);

	cpu_bus_arbiter u_arbiter (
		.clk_6m(clk_6m),
		.reset(reset),
		.slot_sub(slot_sub),
		.main_e(main_e),
		.main_addr(main_addr),
		.main_wdata(main_wdata),
		.main_we(main_we),
		.main_sel_scroll0(main_sel_scroll0),
		.main_sel_scroll1(main_sel_scroll1),
		.main_sel_object(main_sel_object),
		.main_sel_latch0(main_sel_latch0),
		.main_sel_latch1(main_sel_latch1),
		.main_sel_backcolor(main_sel_backcolor),
		.main_rom_sel_c(main_rom_sel_c),
		.main_rom_sel_d(main_rom_sel_d),
		.main_bank(main_bank),
		.main_rdata(main_rdata),
		.sub_addr(sub_addr),
		.sub_wdata(sub_wdata),
		.sub_we(sub_we),
		.sub_sel_scroll0(sub_sel_scroll0),
		.sub_sel_scroll1(sub_sel_scroll1),
		.sub_sel_object(sub_sel_object),
		.sub_sel_latch0(sub_sel_latch0),
		.sub_sel_latch1(sub_sel_latch1),
		.sub_rom_sel_c(sub_rom_sel_c),
		.sub_rom_sel_d(sub_rom_sel_d),
		.sub_rdata(sub_rdata),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_we(bus_we),
		.scroll0(scroll0),
		.scroll1(scroll1),
		.object(object),
		.latch0(latch0),
		.latch1(latch1),
		.backcolor(backcolor),
		.md(md),
		.bus_rdata(bus_rdata),
		.rom_9c_addr(rom_9c_addr),
		.rom_9c_ce(rom_9c_ce),
		.rom_9c_data(rom_9c_data),
		.rom_9d_addr(rom_9d_addr),
		.rom_9d_ce(rom_9d_ce),
		.rom_9d_data(rom_9d_data),
		.rom_12c_addr(rom_12c_addr),
		.rom_12c_ce(rom_12c_ce),
		.rom_12c_data(rom_12c_data),
		.rom_12d_addr(rom_12d_addr),
		.rom_12d_ce(rom_12d_ce),
		.rom_12d_data(rom_12d_data)
	);

endmodule

/* hw/main_addr_decoder.sv */
`timescale 1ns/1ps

module main_addr_decoder import sys86_map_pkg::*; (
	input  logic              clk_6m,
	input  logic              reset,
	input  logic              main_e,
	input  logic              vblank,
	input  logic [addr_w-1:0] addr,
	input  logic [data_w-1:0] wdata,
	input  logic              we,
	output logic              sel_scroll0,
	output logic              sel_scroll1,
	output logic              sel_object,
	output logic              sel_latch0,
	output logic              sel_latch1,
	output logic              sel_backcolor,
	output logic              rom_sel_c,
	output logic              rom_sel_d,
	output logic [bank_w-1:0] bank,
	output logic              irq,
	output logic              hold
);

	logic [win_w-1:0]  win;
	logic [page_w-1:0] page;
	logic              reg_wr;
	logic              hold_q;
	logic              vblank_d;
	logic              vblank_rise;

	assign win = addr[addr_w-1 -: win_w];
	assign page = addr[addr_w-1 -: page_w];

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	// Shared video windows, reads and writes
	assign sel_scroll0 = (win == win_scroll0);
	assign sel_scroll1 = (win == win_scroll1);
	assign sel_object = (win == win_object);

	// Register pages only respond to writes
	assign sel_latch0 = we && (page == reg_latch0[addr_w-1 -: page_w]);
	assign sel_latch1 = we && (page == reg_latch1[addr_w-1 -: page_w]);
	assign sel_backcolor = we && (page == reg_backcolor[addr_w-1 -: page_w]);

	// 9c above 0x8000, banked 9d at 0x6000
	assign rom_sel_c = !we && addr[addr_w-1];
	assign rom_sel_d = !we && (win == win_bank_rom);

	////////////////////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////////////////////

	// Writes take effect at the end of the main bus cycle
	assign reg_wr = main_e && we && addr[addr_w-1];
	assign vblank_rise = vblank && !vblank_d;

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			bank <= '0;
			hold_q <= 1'b0;
			irq <= 1'b0;
			vblank_d <= 1'b0;
		end else begin
			vblank_d <= vblank;
			if (reg_wr && page == reg_bank[addr_w-1 -: page_w]) begin
				bank <= wdata[bank_w-1:0];
			end
			if (reg_wr && page == reg_hold[addr_w-1 -: page_w]) begin
				hold_q <= wdata[0];
			end
			// A new vblank wins over an ack in the same cycle
			if (vblank_rise) begin
				irq <= 1'b1;
			end else if (reg_wr && page == reg_irq_ack[addr_w-1 -: page_w]) begin
				irq <= 1'b0;
			end
		end
	end

	// Sub CPU held in reset by system reset or the hold bit
	assign hold = reset || hold_q;

endmodule

/* hw/sub_addr_decoder.sv */
`timescale 1ns/1ps

module sub_addr_decoder import sys86_map_pkg::*; (
	input  logic              clk_6m,
	input  logic              reset,
	input  logic              sub_e,
	input  logic              vblank,
	input  logic [addr_w-1:0] addr,
	input  logic              we,
	output logic              sel_scroll0,
	output logic              sel_scroll1,
	output logic              sel_object,
	output logic              sel_latch0,
	output logic              sel_latch1,
	output logic              rom_sel_c,
	output logic              rom_sel_d,
	output logic              irq
);

	logic [win_w-1:0]  win;
	logic [page_w-1:0] page;
	logic              ack_wr;
	logic              vblank_d;

	assign win = addr[addr_w-1 -: win_w];
	assign page = addr[addr_w-1 -: page_w];

	// Same shared windows as the main CPU
	assign sel_scroll0 = (win == win_scroll0);
	assign sel_scroll1 = (win == win_scroll1);
	assign sel_object = (win == win_object);

	assign sel_latch0 = we && (page == reg_latch0[addr_w-1 -: page_w]);
	assign sel_latch1 = we && (page == reg_latch1[addr_w-1 -: page_w]);

	// No bank here, 12d sits linearly in its window
	assign rom_sel_c = !we && addr[addr_w-1];
	assign rom_sel_d = !we && (win == win_bank_rom);

	// Sub's own acknowledge, at the end of its bus cycle
	assign ack_wr = sub_e && we && (page == reg_irq_ack[addr_w-1 -: page_w]);

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			irq <= 1'b0;
			vblank_d <= 1'b0;
		end else begin
			vblank_d <= vblank;
			if (vblank && !vblank_d) begin
				irq <= 1'b1;
			end else if (ack_wr) begin
				irq <= 1'b0;
			end
		end
	end

endmodule

/* hw/sys86_map_pkg.sv */
package sys86_map_pkg;

	// CPU side and master bus widths
	localparam int addr_w = 16;
	localparam int bus_addr_w = 13;
	localparam int data_w = 8;
	localparam int rom_addr_w = 15;
	localparam int bank_w = 2;

	// Windows are picked by the top three address bits
	localparam int win_w = 3;
	localparam logic [win_w-1:0] win_scroll0 = 3'd0;
	localparam logic [win_w-1:0] win_scroll1 = 3'd1;
	localparam logic [win_w-1:0] win_object = 3'd2;
	localparam logic [win_w-1:0] win_bank_rom = 3'd3;

	// Register pages decode on bits 15:11
	localparam int page_w = 5;

	////////////////////////////////////////////////////////////////////////////
	// Write-only register pages
	////////////////////////////////////////////////////////////////////////////

	localparam logic [addr_w-1:0] reg_latch0 = 16'h8000;
	localparam logic [addr_w-1:0] reg_latch1 = 16'h8800;
	localparam logic [addr_w-1:0] reg_backcolor = 16'h9000;
	localparam logic [addr_w-1:0] reg_bank = 16'h9800;
	localparam logic [addr_w-1:0] reg_hold = 16'hA000;
	localparam logic [addr_w-1:0] reg_irq_ack = 16'hA800;

endpackage

/* hw/sys86_timing_pkg.sv */
package sys86_timing_pkg;

	// One bus period of clk_6m
	localparam int phase_count = 4;
	localparam int phase_w = 2;

	// Phases 0-1 belong to the main CPU, 2-3 to the sub CPU
	localparam logic [phase_w-1:0] slot_main_last = 2'd1;
	localparam logic [phase_w-1:0] slot_sub_last = 2'd3;

endpackage

/* tb.f */
hw/sys86_map_pkg.sv
hw/sys86_timing_pkg.sv
hw/bus_phase_gen.sv
hw/main_addr_decoder.sv
hw/sub_addr_decoder.sv
hw/cpu_bus_arbiter.sv
hw/cpu_subsystem.sv
bench/cpu_subsystem_sva.sv
bench/tb_cpu_subsystem.sv
